/* sim.f */
source/axi_pkg.sv
source/aw_chan_if.sv
source/b_chan_if.sv
source/aw_router.sv
source/b_return_mux.sv
source/axi_wr_route_top.sv
verif/axi_wr_route_chk.sv
verif/tb_axi_wr_route.sv

/* Bender.yml */
package:
  name: axi_wr_route

sources:
  - source/axi_pkg.sv
  - source/aw_chan_if.sv
  - source/b_chan_if.sv
  - source/aw_router.sv
  - source/b_return_mux.sv
  - source/axi_wr_route_top.sv
  - target: test
    files:
      - verif/axi_wr_route_chk.sv
      - verif/tb_axi_wr_route.sv

/* verif/tb_axi_wr_route.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_axi_wr_route
  import axi_pkg::*;
();

  // About 800 cycles of traffic expected
  localparam int TIMEOUT_CYCLES = 2000;
  localparam axi_master_id_t TAG = AXI_MASTER_1_ID;

  logic                     clk;
  logic                     rstn;
  logic [AXI_ID_BITS-1:0]   awid;
  logic [AXI_ADDR_BITS-1:0] awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [AXI_ID_BITS-1:0]   bid;
  axi_resp_t                bresp;
  logic                     bvalid;
  logic                     bready;

  wire [AXI_IDS_BITS-1:0]   s_awid [3];
  wire [AXI_ADDR_BITS-1:0]  s_awaddr [3];
  wire [2:0]                s_awvalid;
  wire [2:0]                s_bready;
  logic [2:0]               s_awready;
  logic [AXI_IDS_BITS-1:0]  s_bid [3];
  axi_resp_t                s_bresp [3];
  logic [2:0]               s_bvalid;

  // Slave model controls
  logic [2:0]  hold_b;
  logic [2:0]  foreign;
  logic        fast_aw;
  int          bready_mode;

  logic        pending [16];
  axi_resp_t   sent_resp [16];
  int          exp_slave [16];
  int          served [$];
  int          aw_count = 0;
  int          b_count = 0;
  int          dropped = 0;
  int          errors = 0;
  int          tests = 0;
  int          cycles = 0;
  int          next_id = 0;
  logic [31:0] lfsr = 32'hb63d41eb;

  axi_wr_route_top axi_wr_route_top_inst (
    .clk        (clk),
    .rstn       (rstn),
    .awid       (awid),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .bid        (bid),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .s0_awid    (s_awid[0]),
    .s0_awaddr  (s_awaddr[0]),
    .s0_awvalid (s_awvalid[0]),
    .s0_awready (s_awready[0]),
    .s0_bid     (s_bid[0]),
    .s0_bresp   (s_bresp[0]),
    .s0_bvalid  (s_bvalid[0]),
    .s0_bready  (s_bready[0]),
    .s1_awid    (s_awid[1]),
    .s1_awaddr  (s_awaddr[1]),
    .s1_awvalid (s_awvalid[1]),
    .s1_awready (s_awready[1]),
    .s1_bid     (s_bid[1]),
    .s1_bresp   (s_bresp[1]),
    .s1_bvalid  (s_bvalid[1]),
    .s1_bready  (s_bready[1]),
    .s2_awid    (s_awid[2]),
    .s2_awaddr  (s_awaddr[2]),
    .s2_awvalid (s_awvalid[2]),
    .s2_awready (s_awready[2]),
    .s2_bid     (s_bid[2]),
    .s2_bresp   (s_bresp[2]),
    .s2_bvalid  (s_bvalid[2]),
    .s2_bready  (s_bready[2])
  );

  bind axi_wr_route_top axi_wr_route_chk chk_inst (.*);

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Bit 31 set goes to slave 2, else bit 30 picks slave 1
  function automatic int region_of(input logic [AXI_ADDR_BITS-1:0] addr);
    if (addr[31])
      return 2;
    if (addr[30])
      return 1;
    return 0;
  endfunction

  function automatic int total_errors();
    return errors + axi_wr_route_top_inst.chk_inst.fails;
  endfunction

  task automatic check_that(input logic ok, input string msg);
    assert (ok) else begin
      $display("Fail at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic start_aw(input logic [AXI_ADDR_BITS-1:0] addr);
    exp_slave[next_id] = region_of(addr);
    awid    = 4'(next_id);
    awaddr  = addr;
    awvalid = 1'b1;
    next_id = (next_id + 1) % 16;
  endtask

  task automatic finish_aw();
    do @(negedge clk); while (!awready);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
  endtask

  task automatic write_aw(input logic [AXI_ADDR_BITS-1:0] addr);
    start_aw(addr);
    finish_aw();
  endtask

  task automatic wait_drained();
    @(posedge clk);
    while (b_count != aw_count - dropped) @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input string name, input int e0);
    tests++;
    $display("Test %0d %s done with %0d errors", tests, name, total_errors() - e0);
  endtask

  // Accepts AW, queues the ID and answers with a random code
  task automatic slave_model(input int k);
    logic [AXI_IDS_BITS-1:0] q [$];
    logic [AXI_IDS_BITS-1:0] id;
    logic [AXI_IDS_BITS-1:0] aw_id;
    logic                    aw_hit;
    logic                    b_hit;
    forever begin
      @(negedge clk);
      aw_hit = s_awvalid[k] && s_awready[k];
      b_hit  = s_bvalid[k] && s_bready[k];
      aw_id  = s_awid[k];
      if (aw_hit) begin
        check_that(aw_id[AXI_IDS_BITS-1 -: AXI_TAG_BITS] == TAG, "AW ID lacks the master tag");
        check_that(exp_slave[aw_id[AXI_ID_BITS-1:0]] == k, "AW reached the wrong slave");
        check_that(s_awaddr[k] == awaddr, "AW address differs from the master address");
      end
      @(posedge clk);
      #1;
      if (aw_hit)
        q.push_back(aw_id);
      if (b_hit)
        s_bvalid[k] = 1'b0;
      if (!s_bvalid[k] && q.size() > 0 && !hold_b[k] && rand_bits(2) != 0) begin
        id = q.pop_front();
        if (foreign[k])
          id[AXI_IDS_BITS-1 -: AXI_TAG_BITS] = AXI_MASTER_2_ID;
        s_bid[k]   = id;
        s_bresp[k] = axi_resp_t'(2'(rand_bits(2)));
        sent_resp[id[AXI_ID_BITS-1:0]] = s_bresp[k];
        s_bvalid[k] = 1'b1;
      end
      s_awready[k] = fast_aw || (rand_bits(2) != 0);
    end
  endtask

  // Master side scoreboard and bready driver
  task automatic watch_master();
    forever begin
      @(negedge clk);
      if (rstn && awvalid && awready) begin
        check_that(!pending[awid], "AW issued with an ID still in flight");
        pending[awid] = 1'b1;
        aw_count++;
      end
      if (rstn && bvalid && bready) begin
        check_that(pending[bid], "B returned for an ID with no write in flight");
        check_that(bresp == sent_resp[bid], $sformatf("B code %0d for ID %0d", bresp, bid));
        pending[bid] = 1'b0;
        b_count++;
        for (int k = 0; k < 3; k++) begin
          if (s_bready[k])
            served.push_back(k);
        end
      end
      @(posedge clk);
      #1;
      case (bready_mode)
        0:       bready = 1'b0;
        1:       bready = 1'b1;
        default: bready = (rand_bits(1) != 0);
      endcase
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run timed out after %0d cycles", cycles);
    $display("Something failed");
    $finish;
  end

  initial begin
    int e0;
    int id0;
    int base;
    awid = '0;
    awaddr = '0;
    awvalid = 1'b0;
    bready = 1'b0;
    s_awready = 3'b000;
    s_bvalid = 3'b000;
    for (int k = 0; k < 3; k++) begin
      s_bid[k] = '0;
      s_bresp[k] = RESP_OKAY;
    end
    for (int i = 0; i < 16; i++) begin
      pending[i] = 1'b0;
      exp_slave[i] = 0;
      sent_resp[i] = RESP_OKAY;
    end
    hold_b = 3'b000;
    foreign = 3'b000;
    fast_aw = 1'b0;
    bready_mode = 1;
    rstn = 1'b0;
    fork
      slave_model(0);
      slave_model(1);
      slave_model(2);
      watch_master();
    join_none
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;

    e0 = total_errors();
    write_aw(32'h0000_1000);
    write_aw(32'h4000_2000);
    write_aw(32'h8000_0000);
    write_aw(32'hc000_0010);
    wait_drained();
    finish_test("routing", e0);

    // All three slaves valid while the master stalls
    e0 = total_errors();
    @(negedge clk);
    hold_b = 3'b111;
    bready_mode = 0;
    fast_aw = 1'b1;
    @(posedge clk);
    #1;
    write_aw(32'h0000_0100);
    write_aw(32'h4000_0100);
    write_aw(32'h8000_0100);
    // Slave 0 first so the lock starts there
    @(negedge clk);
    hold_b = 3'b110;
    served.delete();
    do @(negedge clk); while (!s_bvalid[0]);
    hold_b = 3'b000;
    do @(negedge clk); while (s_bvalid != 3'b111);
    repeat (5) @(negedge clk);
    check_that(bvalid && s_bready == 3'b000, "slave bready high while the master stalls");
    bready_mode = 1;
    finish_test("stall", e0);
    e0 = total_errors();
    wait_drained();
    check_that(served.size() == 3 && served[0] == 0 && served[1] == 1 && served[2] == 2,
               $sformatf("rotation order %p, expected 0 1 2", served));
    finish_test("rotation", e0);

    e0 = total_errors();
    @(negedge clk);
    hold_b = 3'b111;
    @(posedge clk);
    #1;
    for (int i = 0; i < 4; i++) begin
      write_aw(32'h4000_0000 + 32'(i * 16));
    end
    start_aw(32'h4000_0040);
    repeat (3) begin
      @(negedge clk);
      check_that(!awready && s_awvalid == 3'b000, "AW passed at the outstanding limit");
    end
    hold_b[1] = 1'b0;
    base = b_count;
    do @(posedge clk); while (b_count == base);
    @(negedge clk);
    check_that(awready, "awready still low after a B transfer");
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wait_drained();
    finish_test("outstanding limit", e0);

    e0 = total_errors();
    @(negedge clk);
    hold_b = 3'b000;
    fast_aw = 1'b0;
    bready_mode = 2;
    @(posedge clk);
    #1;
    repeat (200) write_aw(rand_bits(32));
    wait_drained();
    finish_test("random traffic", e0);

    // Response tagged for another master
    e0 = total_errors();
    @(negedge clk);
    foreign = 3'b001;
    bready_mode = 1;
    fast_aw = 1'b1;
    @(posedge clk);
    #1;
    base = b_count;
    id0 = next_id;
    write_aw(32'h0000_0200);
    do @(negedge clk); while (!s_bvalid[0]);
    check_that(s_bready[0] && !bvalid, "foreign response not drained at once");
    @(negedge clk);
    check_that(!s_bvalid[0], "foreign response still held by the slave");
    @(posedge clk);
    #1;
    check_that(b_count == base, "foreign response reached the master");
    pending[id0] = 1'b0;
    dropped++;
    finish_test("foreign drain", e0);

    $display("Tests %0d, check errors %0d, assertion errors %0d",
             tests, errors, axi_wr_route_top_inst.chk_inst.fails);
    if (total_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/axi_wr_route_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_wr_route_chk
  import axi_pkg::*;
(
  input logic                   clk,
  input logic                   rstn,
  input logic [AXI_ID_BITS-1:0] awid,
  input logic                   awvalid,
  input logic                   awready,
  input logic [AXI_ID_BITS-1:0] bid,
  input axi_resp_t              bresp,
  input logic                   bvalid,
  input logic                   bready,
  input logic                   s0_awvalid,
  input logic                   s1_awvalid,
  input logic                   s2_awvalid,
  input logic                   s0_bready,
  input logic                   s1_bready,
  input logic                   s2_bready
);

  logic [2:0]  slv_awvalid;
  logic [2:0]  slv_bready;
  int unsigned pend [16];
  int          fails = 0;

  assign slv_awvalid = {s2_awvalid, s1_awvalid, s0_awvalid};
  assign slv_bready  = {s2_bready, s1_bready, s0_bready};

  // Writes in flight per master ID
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 16; i++) begin
        pend[i] <= 0;
      end
    end else begin
      for (int i = 0; i < 16; i++) begin
        if (awvalid && awready && awid == 4'(i) &&
            !(bvalid && bready && bid == 4'(i))) begin
          pend[i] <= pend[i] + 1;
        end else if (bvalid && bready && bid == 4'(i) &&
                     !(awvalid && awready && awid == 4'(i))) begin
          pend[i] <= pend[i] - 1;
        end
      end
    end
  end

  a_b_stable: assert property (@(posedge clk) disable iff (!rstn)
    bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
    else begin $error("B payload changed while the master stalled"); fails++; end

  a_b_ready_one: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0(slv_bready) && (!bvalid || ((|slv_bready) == bready)))
    else begin $error("Slave bready does not follow the master"); fails++; end

  a_aw_one: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0(slv_awvalid) && (!(|slv_awvalid) || awvalid))
    else begin $error("AW valid reached a wrong or extra slave"); fails++; end

  a_b_known_id: assert property (@(posedge clk) disable iff (!rstn)
    bvalid |-> pend[bid] != 0)
    else begin $error("B valid without a matching write in flight"); fails++; end

endmodule

`default_nettype wire

/* source/axi_wr_route_top.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_wr_route_top
  import axi_pkg::*;
#(
  parameter axi_master_id_t MASTER_TAG      = AXI_MASTER_1_ID,
  parameter int             MAX_OUTSTANDING = 4
) (
  input  logic                     clk,
  input  logic                     rstn,
  // Master AW
  input  logic [AXI_ID_BITS-1:0]   awid,
  input  logic [AXI_ADDR_BITS-1:0] awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  // Master B
  output logic [AXI_ID_BITS-1:0]   bid,
  output axi_resp_t                bresp,
  output logic                     bvalid,
  input  logic                     bready,
  // Slave 0
  output logic [AXI_IDS_BITS-1:0]  s0_awid,
  output logic [AXI_ADDR_BITS-1:0] s0_awaddr,
  output logic                     s0_awvalid,
  input  logic                     s0_awready,
  input  logic [AXI_IDS_BITS-1:0]  s0_bid,
  input  axi_resp_t                s0_bresp,
  input  logic                     s0_bvalid,
  output logic                     s0_bready,
  // Slave 1
  output logic [AXI_IDS_BITS-1:0]  s1_awid,
  output logic [AXI_ADDR_BITS-1:0] s1_awaddr,
  output logic                     s1_awvalid,
  input  logic                     s1_awready,
  input  logic [AXI_IDS_BITS-1:0]  s1_bid,
  input  axi_resp_t                s1_bresp,
  input  logic                     s1_bvalid,
  output logic                     s1_bready,
  // Slave 2
  output logic [AXI_IDS_BITS-1:0]  s2_awid,
  output logic [AXI_ADDR_BITS-1:0] s2_awaddr,
  output logic                     s2_awvalid,
  input  logic                     s2_awready,
  input  logic [AXI_IDS_BITS-1:0]  s2_bid,
  input  axi_resp_t                s2_bresp,
  input  logic                     s2_bvalid,
  output logic                     s2_bready
);

  logic b_done;

  aw_chan_if aw_if [3] ();
  b_chan_if  b_if  [3] ();

  assign s0_awid          = aw_if[0].awid;
  assign s0_awaddr        = aw_if[0].awaddr;
  assign s0_awvalid       = aw_if[0].awvalid;
  assign aw_if[0].awready = s0_awready;
  assign b_if[0].bid      = s0_bid;
  assign b_if[0].bresp    = s0_bresp;
  assign b_if[0].bvalid   = s0_bvalid;
  assign s0_bready        = b_if[0].bready;

  assign s1_awid          = aw_if[1].awid;
  assign s1_awaddr        = aw_if[1].awaddr;
  assign s1_awvalid       = aw_if[1].awvalid;
  assign aw_if[1].awready = s1_awready;
  assign b_if[1].bid      = s1_bid;
  assign b_if[1].bresp    = s1_bresp;
  assign b_if[1].bvalid   = s1_bvalid;
  assign s1_bready        = b_if[1].bready;

  assign s2_awid          = aw_if[2].awid;
  assign s2_awaddr        = aw_if[2].awaddr;
  assign s2_awvalid       = aw_if[2].awvalid;
  assign aw_if[2].awready = s2_awready;
  assign b_if[2].bid      = s2_bid;
  assign b_if[2].bresp    = s2_bresp;
  assign b_if[2].bvalid   = s2_bvalid;
  assign s2_bready        = b_if[2].bready;

  aw_router #(
    .MASTER_TAG      (MASTER_TAG),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) aw_router_inst (
    .clk     (clk),
    .rstn    (rstn),
    .awid    (awid),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .b_done  (b_done),
    .slv     (aw_if)
  );

  b_return_mux #(
    .MASTER_TAG (MASTER_TAG)
  ) b_return_mux_inst (
    .clk    (clk),
    .rstn   (rstn),
    .bid    (bid),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .b_done (b_done),
    .slv    (b_if)
  );

endmodule

`default_nettype wire

/* source/b_return_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module b_return_mux
  import axi_pkg::*;
#(
  parameter axi_master_id_t MASTER_TAG = AXI_MASTER_1_ID
) (
  input  logic                   clk,
  input  logic                   rstn,
  output logic [AXI_ID_BITS-1:0] bid,
  output axi_resp_t              bresp,
  output logic                   bvalid,
  input  logic                   bready,
  output logic                   b_done,
  b_chan_if.ret                  slv [3]
);

  logic [2:0]              vld;
  logic [2:0]              rdy;
  logic [AXI_IDS_BITS-1:0] id_s [3];
  axi_resp_t               resp_s [3];

  b_lock_t        lock;
  b_lock_t        lock_next;
  logic [1:0]     cur;
  logic [1:0]     nxt1;
  logic [1:0]     nxt2;
  logic           cur_vld;
  logic           cur_rdy;
  logic           own;
  axi_master_id_t tag;

  function automatic b_lock_t to_lock(input logic [1:0] idx);
    case (idx)
      2'd0:    return LOCK_S0;
      2'd1:    return LOCK_S1;
      default: return LOCK_S2;
    endcase
  endfunction

  for (genvar i = 0; i < 3; i++) begin : g_slv
    assign vld[i]         = slv[i].bvalid;
    assign id_s[i]        = slv[i].bid;
    assign resp_s[i]      = slv[i].bresp;
    assign slv[i].bready  = rdy[i];
  end

  // Presented slave, lowest valid when unlocked
  always_comb begin
    case (lock)
      LOCK_S0: cur = 2'd0;
      LOCK_S1: cur = 2'd1;
      LOCK_S2: cur = 2'd2;
      default: cur = vld[0] ? 2'd0 : (vld[1] ? 2'd1 : 2'd2);
    endcase
  end

  assign cur_vld = vld[cur];

  // Tag decode, foreign responses are drained
  assign tag     = axi_master_id_t'(id_s[cur][AXI_IDS_BITS-1 -: AXI_TAG_BITS]);
  assign own     = (tag == MASTER_TAG);
  assign cur_rdy = own ? bready : 1'b1;

  assign bid    = id_s[cur][AXI_ID_BITS-1:0];
  assign bresp  = resp_s[cur];
  assign bvalid = cur_vld && own;
  assign b_done = bvalid && bready;

  always_comb begin
    rdy      = 3'b000;
    rdy[cur] = cur_vld && cur_rdy;
  end

  assign nxt1 = (cur == 2'd2) ? 2'd0 : cur + 2'd1;
  assign nxt2 = (nxt1 == 2'd2) ? 2'd0 : nxt1 + 2'd1;

  // Hold on stall, rotate past the served slave on a transfer
  always_comb begin
    lock_next = LOCK_NO;
    if (cur_vld && !cur_rdy) begin
      lock_next = to_lock(cur);
    end else if (cur_vld) begin
      if (vld[nxt1]) begin
        lock_next = to_lock(nxt1);
      end else if (vld[nxt2]) begin
        lock_next = to_lock(nxt2);
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock <= LOCK_NO;
    end else begin
      lock <= lock_next;
    end
  end

endmodule

`default_nettype wire

/* source/aw_router.sv */
`timescale 1ns/1ns
`default_nettype none

module aw_router
  import axi_pkg::*;
#(
  parameter axi_master_id_t MASTER_TAG      = AXI_MASTER_1_ID,
  parameter int             MAX_OUTSTANDING = 4
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic [AXI_ID_BITS-1:0]   awid,
  input  logic [AXI_ADDR_BITS-1:0] awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic                     b_done,
  aw_chan_if.router                slv [3]
);

  localparam int CNT_BITS = $clog2(MAX_OUTSTANDING + 1);

  logic [1:0]          sel;
  logic [2:0]          slv_rdy;
  logic [CNT_BITS-1:0] count;
  logic                full;
  logic                aw_fire;

  assign sel  = slave_decode(awaddr);
  assign full = (count == CNT_BITS'(MAX_OUTSTANDING));

  // Only the decoded slave sees the address
  for (genvar i = 0; i < 3; i++) begin : g_slv
    assign slv[i].awid    = {MASTER_TAG, awid};
    assign slv[i].awaddr  = awaddr;
    assign slv[i].awvalid = awvalid && !full && (sel == 2'(i));
    assign slv_rdy[i]     = slv[i].awready;
  end

  assign awready = !full && slv_rdy[sel];
  assign aw_fire = awvalid && awready;

  // Writes in flight without a returned response
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      count <= '0;
    end else begin
      case ({aw_fire, b_done})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/b_chan_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface b_chan_if
  import axi_pkg::*;
();

  logic [AXI_IDS_BITS-1:0] bid;
  axi_resp_t               bresp;
  logic                    bvalid;
  logic                    bready;

  modport slave (
    output bid, bresp, bvalid,
    input  bready
  );

  // Return path toward the master
  modport ret (
    input  bid, bresp, bvalid,
    output bready
  );

endinterface

`default_nettype wire

/* source/aw_chan_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface aw_chan_if
  import axi_pkg::*;
();

  logic [AXI_IDS_BITS-1:0]  awid;
  logic [AXI_ADDR_BITS-1:0] awaddr;
  logic                     awvalid;
  logic                     awready;

  modport router (
    output awid, awaddr, awvalid,
    input  awready
  );

  modport slave (
    input  awid, awaddr, awvalid,
    output awready
  );

endinterface

`default_nettype wire

/* source/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  localparam int AXI_ID_BITS   = 4;
  localparam int AXI_TAG_BITS  = 2;
  // Slave side carries the master tag above the master ID
  localparam int AXI_IDS_BITS  = AXI_TAG_BITS + AXI_ID_BITS;
  localparam int AXI_ADDR_BITS = 32;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

  typedef enum logic [1:0] {
    AXI_MASTER_0_ID = 2'd0,
    AXI_MASTER_1_ID = 2'd1,
    AXI_MASTER_2_ID = 2'd2,
    AXI_MASTER_U_ID = 2'd3
  } axi_master_id_t;

  typedef enum logic [1:0] {
    LOCK_NO = 2'd0,
    LOCK_S0 = 2'd1,
    LOCK_S1 = 2'd2,
    LOCK_S2 = 2'd3
  } b_lock_t;

  // Top two address bits pick the slave, upper half all goes to slave 2
  function automatic logic [1:0] slave_decode(input logic [AXI_ADDR_BITS-1:0] addr);
    logic [1:0] region;
    region = addr[AXI_ADDR_BITS-1 -: 2];
    case (region)
      2'b00:   return 2'd0;
      2'b01:   return 2'd1;
      default: return 2'd2;
    endcase
  endfunction

endpackage

`default_nettype wire
